// File: source/rv_core_pkg.sv
package rv_core_pkg;

  localparam int xlen = 32;
  localparam int nr_gpr = 16;
  localparam int gpr_aw = $clog2(nr_gpr);

  // major opcodes.
  localparam logic [6:0] opc_op = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_system = 7'b1110011;

  localparam logic [2:0] f3_add = 3'b000;
  localparam logic [2:0] f3_priv = 3'b000;
  localparam logic [2:0] f3_csrrw = 3'b001;
  localparam logic [2:0] f3_csrrs = 3'b010;
  localparam logic [6:0] f7_add = 7'b0000000;

  // imm12 tells the two privileged system instructions apart.
  localparam logic [11:0] imm_ecall = 12'h000;
  localparam logic [11:0] imm_mret = 12'h302;

  localparam logic [11:0] csr_mstatus = 12'h300;
  localparam logic [11:0] csr_mtvec = 12'h305;
  localparam logic [11:0] csr_mepc = 12'h341;
  localparam logic [11:0] csr_mcause = 12'h342;
  localparam logic [11:0] csr_mvendorid = 12'hF11;
  localparam logic [11:0] csr_marchid = 12'hF12;

  localparam logic [xlen-1:0] mstatus_rst = 32'h1800;
  localparam logic [xlen-1:0] mvendorid_val = 32'h79737978;
  localparam logic [xlen-1:0] marchid_val = 32'h017DC685;
  localparam logic [xlen-1:0] mcause_ecall = 32'd11;

  // mstatus bit positions.
  localparam int mstatus_mie = 3;
  localparam int mstatus_mpie = 7;
  localparam int mstatus_mpp_lo = 11;
  localparam int mstatus_mpp_hi = 12;

  typedef enum logic [2:0] {
    op_add,
    op_addi,
    op_csrrw,
    op_csrrs,
    op_ecall,
    op_mret,
    op_illegal
  } op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fields_t;

  // imm12 doubles as the csr address.
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fields_t;

  typedef union packed {
    r_fields_t r;
    i_fields_t i;
  } inst_u;

  typedef struct packed {
    op_e              op;
    logic [xlen-1:0]  pc;
    logic [gpr_aw-1:0] rd;
    logic [gpr_aw-1:0] rs1;
    logic [gpr_aw-1:0] rs2;
    logic [xlen-1:0]  imm;
    logic [11:0]      csr_addr;
  } dec_bus_t;

  typedef struct packed {
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] csr_data;
  } operand_t;

  typedef struct packed {
    logic              gpr_wen;
    logic [gpr_aw-1:0] rd;
    logic [xlen-1:0]   gpr_wdata;
    logic              csr_wen;
    logic [11:0]       csr_addr;
    logic [xlen-1:0]   csr_wdata;
    logic              ecall;
    logic              mret;
    logic [xlen-1:0]   pc;
  } wb_req_t;

  typedef struct packed {
    logic [xlen-1:0]   pc;
    logic [gpr_aw-1:0] rd;
    logic              rd_wen;
    logic [xlen-1:0]   rd_data;
    logic [xlen-1:0]   next_pc;
    logic              illegal;
  } commit_t;

endpackage

// File: source/inst_decode.sv
module inst_decode
  import rv_core_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,
  input  logic            inst_valid,
  input  inst_u           inst,
  input  logic [31:0]     pc,
  output logic            dec_valid,
  output dec_bus_t        dec
);

  dec_bus_t dec_nxt;
  op_e      op_sys;

  // privileged system ops share funct3 and differ only in imm12.
  always_comb begin
    op_sys = op_illegal;
    case (inst.r.funct3)
      f3_priv: begin
        if (inst.i.imm12 == imm_ecall) begin
          op_sys = op_ecall;
        end else if (inst.i.imm12 == imm_mret) begin
          op_sys = op_mret;
        end
      end
      f3_csrrw: begin
        op_sys = op_csrrw;
      end
      f3_csrrs: begin
        op_sys = op_csrrs;
      end
      default: begin
        op_sys = op_illegal;
      end
    endcase
  end

  always_comb begin
    dec_nxt.pc = pc;
    dec_nxt.rd = inst.r.rd[gpr_aw-1:0];
    dec_nxt.rs1 = inst.r.rs1[gpr_aw-1:0];
    dec_nxt.rs2 = inst.r.rs2[gpr_aw-1:0];
    dec_nxt.imm = {{(xlen-12){inst.i.imm12[11]}}, inst.i.imm12};
    dec_nxt.csr_addr = inst.i.imm12;
    dec_nxt.op = op_illegal;

    case (inst.r.opcode)
      opc_op: begin
        if (inst.r.funct3 == f3_add && inst.r.funct7 == f7_add) begin
          dec_nxt.op = op_add;
        end
      end
      opc_op_imm: begin
        if (inst.r.funct3 == f3_add) begin
          dec_nxt.op = op_addi;
        end
      end
      opc_system: begin
        dec_nxt.op = op_sys;
      end
      default: begin
        dec_nxt.op = op_illegal;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= inst_valid;
    end
  end

  // bundle only moves when a new instruction arrives.
  always_ff @(posedge clk) begin
    if (inst_valid) begin
      dec <= dec_nxt;
    end
  end

endmodule

// File: source/gpr_csr_file.sv
module gpr_csr_file
  import rv_core_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     dec_valid,
  input  dec_bus_t dec,
  input  wb_req_t  wb,
  output operand_t opnd
);

  logic [xlen-1:0] gpr [nr_gpr];
  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] mcause;
  logic [xlen-1:0] csr_rd;
  logic [xlen-1:0] mstatus_mret;

  // unknown csr addresses read as zero.
  always_comb begin
    case (dec.csr_addr)
      csr_mstatus: begin
        csr_rd = mstatus;
      end
      csr_mtvec: begin
        csr_rd = mtvec;
      end
      csr_mepc: begin
        csr_rd = mepc;
      end
      csr_mcause: begin
        csr_rd = mcause;
      end
      csr_mvendorid: begin
        csr_rd = mvendorid_val;
      end
      csr_marchid: begin
        csr_rd = marchid_val;
      end
      default: begin
        csr_rd = '0;
      end
    endcase
  end

  // trap ops read the vector they jump to.
  always_comb begin
    opnd.src1 = gpr[dec.rs1];
    opnd.src2 = gpr[dec.rs2];
    if (dec.op == op_ecall) begin
      opnd.csr_data = mtvec;
    end else if (dec.op == op_mret) begin
      opnd.csr_data = mepc;
    end else begin
      opnd.csr_data = csr_rd;
    end
  end

  // mret restores mie from mpie, sets mpie and drops to user mode.
  always_comb begin
    mstatus_mret = mstatus;
    mstatus_mret[mstatus_mie] = mstatus[mstatus_mpie];
    mstatus_mret[mstatus_mpie] = 1'b1;
    mstatus_mret[mstatus_mpp_hi:mstatus_mpp_lo] = 2'b00;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < nr_gpr; i++) begin
        gpr[i] <= '0;
      end
    end else if (dec_valid && wb.gpr_wen && (wb.rd != '0)) begin
      gpr[wb.rd] <= wb.gpr_wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus <= mstatus_rst;
      mtvec <= '0;
      mepc <= '0;
      mcause <= '0;
    end else if (dec_valid) begin
      if (wb.ecall) begin
        mepc <= wb.pc;
        mcause <= mcause_ecall;
        mstatus <= mstatus_rst;
      end else if (wb.mret) begin
        mstatus <= mstatus_mret;
      end else if (wb.csr_wen) begin
        // read-only and unknown addresses fall through.
        case (wb.csr_addr)
          csr_mstatus: begin
            mstatus <= wb.csr_wdata;
          end
          csr_mtvec: begin
            mtvec <= wb.csr_wdata;
          end
          csr_mepc: begin
            mepc <= wb.csr_wdata;
          end
          csr_mcause: begin
            mcause <= wb.csr_wdata;
          end
        endcase
      end
    end
  end

endmodule

// File: source/exec_commit.sv
module exec_commit
  import rv_core_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     dec_valid,
  input  dec_bus_t dec,
  input  operand_t opnd,
  output wb_req_t  wb,
  output logic     commit_valid,
  output commit_t  commit
);

  logic [xlen-1:0] add_b;
  logic [xlen-1:0] sum;
  logic [xlen-1:0] seq_pc;
  logic [xlen-1:0] next_pc;
  logic            illegal;

  // addi shares the adder with add.
  assign add_b = (dec.op == op_addi) ? dec.imm : opnd.src2;
  assign sum = opnd.src1 + add_b;
  assign seq_pc = dec.pc + 32'd4;

  always_comb begin
    wb.gpr_wen = 1'b0;
    wb.rd = dec.rd;
    wb.gpr_wdata = sum;
    wb.csr_wen = 1'b0;
    wb.csr_addr = dec.csr_addr;
    wb.csr_wdata = opnd.src1;
    wb.ecall = 1'b0;
    wb.mret = 1'b0;
    wb.pc = dec.pc;
    next_pc = seq_pc;
    illegal = 1'b0;

    case (dec.op)
      op_add, op_addi: begin
        wb.gpr_wen = 1'b1;
      end
      op_csrrw: begin
        wb.gpr_wen = 1'b1;
        wb.gpr_wdata = opnd.csr_data;
        wb.csr_wen = 1'b1;
      end
      op_csrrs: begin
        wb.gpr_wen = 1'b1;
        wb.gpr_wdata = opnd.csr_data;
        wb.csr_wen = 1'b1;
        wb.csr_wdata = opnd.csr_data | opnd.src1;
      end
      // csr_data already carries mtvec or mepc for the trap ops.
      op_ecall: begin
        wb.ecall = 1'b1;
        next_pc = opnd.csr_data;
      end
      op_mret: begin
        wb.mret = 1'b1;
        next_pc = opnd.csr_data;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      commit_valid <= 1'b0;
    end else begin
      commit_valid <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid) begin
      commit.pc <= dec.pc;
      commit.rd <= dec.rd;
      commit.rd_wen <= wb.gpr_wen;
      commit.rd_data <= wb.gpr_wdata;
      commit.next_pc <= next_pc;
      commit.illegal <= illegal;
    end
  end

endmodule

// File: source/rv_operand_top.sv
module rv_operand_top
  import rv_core_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        inst_valid,
  input  logic [31:0] inst,
  input  logic [31:0] pc,
  output logic        commit_valid,
  output commit_t     commit
);

  logic     dec_valid;
  dec_bus_t dec;
  operand_t opnd;
  wb_req_t  wb;

  inst_decode u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .pc         (pc),
    .dec_valid  (dec_valid),
    .dec        (dec)
  );

  gpr_csr_file u_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .dec_valid (dec_valid),
    .dec       (dec),
    .wb        (wb),
    .opnd      (opnd)
  );

  exec_commit u_commit (
    .clk          (clk),
    .rst_n        (rst_n),
    .dec_valid    (dec_valid),
    .dec          (dec),
    .opnd         (opnd),
    .wb           (wb),
    .commit_valid (commit_valid),
    .commit       (commit)
  );

endmodule

// File: sim/clk_gen.sv
module clk_gen #(
  parameter int period = 8
) (
  output logic clk
);

  // free-running clock that starts low.
  initial begin
    clk = 1'b0;
  end

  always begin
    #(period / 2);
    clk = ~clk;
  end

endmodule

// File: sim/tb_rv_operand_top.sv
module tb_rv_operand_top
  import rv_core_pkg::*;
();

  typedef struct packed {
    logic [31:0] inst;
    logic [31:0] pc;
    logic        rd_wen;
    logic [3:0]  rd;
    logic [31:0] rd_data;
    logic [31:0] next_pc;
    logic        illegal;
  } vec_t;

  typedef struct packed {
    logic [31:0] idx;
    logic [31:0] issue_cyc;
  } pend_t;

  logic        clk;
  logic        rst_n;
  logic        inst_valid;
  logic [31:0] inst;
  logic [31:0] pc;
  logic        commit_valid;
  commit_t     commit;

  vec_t        vecs[$];
  string       names[$];
  pend_t       pend_q[$];
  logic [31:0] cycle_cnt = '0;

  clk_gen #(.period(8)) u_clk (.clk(clk));

  rv_operand_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .pc           (pc),
    .commit_valid (commit_valid),
    .commit       (commit)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      abort_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] rand_pc();
    logic [31:0] r;
    r = $urandom;
    return {r[31:2], 2'b00};
  endfunction

  function automatic logic [31:0] enc_add(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  // funct3 001 is csrrw, 010 is csrrs.
  function automatic logic [31:0] enc_csr(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [11:0] csr, input logic [4:0] rs1);
    return {csr, rs1, f3, rd, 7'b1110011};
  endfunction

  // mie takes mpie, mpie is set, mpp is cleared.
  function automatic logic [31:0] mret_rule(input logic [31:0] v);
    logic [31:0] r;
    r = v;
    r[3] = v[7];
    r[7] = 1'b1;
    r[12:11] = 2'b00;
    return r;
  endfunction

  task automatic add_vec(input string name, input logic [31:0] inst_w, input logic [31:0] pc_w,
                         input logic wen, input logic [3:0] rd, input logic [31:0] data,
                         input logic [31:0] npc, input logic ill);
    vec_t v;
    v.inst = inst_w;
    v.pc = pc_w;
    v.rd_wen = wen;
    v.rd = rd;
    v.rd_data = data;
    v.next_pc = npc;
    v.illegal = ill;
    vecs.push_back(v);
    names.push_back(name);
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    logic [11:0] imm_a;
    logic [11:0] imm_b;
    logic [31:0] x1v;
    logic [31:0] x2v;
    logic [31:0] x3v;
    logic [31:0] mtvec_v;
    logic [31:0] ecall_pc;
    logic [31:0] mstatus_v;
    logic [31:0] p;
    rnd = $urandom;
    imm_a = rnd[11:0];
    rnd = $urandom;
    imm_b = rnd[11:0];
    x1v = sext12(imm_a);
    x2v = x1v + sext12(imm_b);
    x3v = x1v + x2v;
    p = rand_pc();
    add_vec("addi_x1", enc_addi(1, 0, imm_a), p, 1, 1, x1v, p + 4, 0);
    p = rand_pc();
    add_vec("addi_x2_dep", enc_addi(2, 1, imm_b), p, 1, 2, x2v, p + 4, 0);
    p = rand_pc();
    add_vec("add_x3_dep", enc_add(3, 1, 2), p, 1, 3, x3v, p + 4, 0);
    p = rand_pc();
    add_vec("add_x3_chain", enc_add(3, 3, 2), p, 1, 3, x3v + x2v, p + 4, 0);
    p = rand_pc();
    add_vec("addi_x0", enc_addi(0, 1, 12'h005), p, 1, 0, x1v + 5, p + 4, 0);
    p = rand_pc();
    add_vec("add_read_x0", enc_add(4, 0, 0), p, 1, 4, 0, p + 4, 0);
    // mtvec takes the value of x2.
    mtvec_v = x2v;
    p = rand_pc();
    add_vec("csrrw_mtvec", enc_csr(3'b001, 5, csr_mtvec, 2), p, 1, 5, 0, p + 4, 0);
    p = rand_pc();
    add_vec("csrrs_mtvec", enc_csr(3'b010, 6, csr_mtvec, 0), p, 1, 6, mtvec_v, p + 4, 0);
    p = rand_pc();
    add_vec("csrrs_mstatus_rst", enc_csr(3'b010, 7, csr_mstatus, 0), p, 1, 7, 32'h1800,
            p + 4, 0);
    p = rand_pc();
    add_vec("csrrs_mvendorid", enc_csr(3'b010, 8, csr_mvendorid, 0), p, 1, 8, 32'h79737978,
            p + 4, 0);
    p = rand_pc();
    add_vec("csrrw_mvendorid", enc_csr(3'b001, 9, csr_mvendorid, 2), p, 1, 9, 32'h79737978,
            p + 4, 0);
    p = rand_pc();
    add_vec("csrrs_mvendorid_after", enc_csr(3'b010, 10, csr_mvendorid, 0), p, 1, 10,
            32'h79737978, p + 4, 0);
    p = rand_pc();
    add_vec("csrrs_marchid", enc_csr(3'b010, 8, csr_marchid, 0), p, 1, 8, 32'h017DC685,
            p + 4, 0);
    p = rand_pc();
    add_vec("csrrw_marchid", enc_csr(3'b001, 9, csr_marchid, 1), p, 1, 9, 32'h017DC685,
            p + 4, 0);
    p = rand_pc();
    add_vec("csrrs_marchid_after", enc_csr(3'b010, 10, csr_marchid, 0), p, 1, 10,
            32'h017DC685, p + 4, 0);
    ecall_pc = rand_pc();
    add_vec("ecall", 32'h0000_0073, ecall_pc, 0, 0, 0, mtvec_v, 0);
    p = rand_pc();
    add_vec("csrrs_mepc", enc_csr(3'b010, 11, csr_mepc, 0), p, 1, 11, ecall_pc, p + 4, 0);
    p = rand_pc();
    add_vec("csrrs_mcause", enc_csr(3'b010, 12, csr_mcause, 0), p, 1, 12, 11, p + 4, 0);
    p = rand_pc();
    add_vec("csrrs_mstatus_ecall", enc_csr(3'b010, 13, csr_mstatus, 0), p, 1, 13, 32'h1800,
            p + 4, 0);
    mstatus_v = 32'h1800;
    p = rand_pc();
    add_vec("addi_mpie_mask", enc_addi(15, 0, 12'h080), p, 1, 15, 32'h80, p + 4, 0);
    p = rand_pc();
    add_vec("csrrs_set_mpie", enc_csr(3'b010, 14, csr_mstatus, 15), p, 1, 14, mstatus_v,
            p + 4, 0);
    mstatus_v = mstatus_v | 32'h80;
    p = rand_pc();
    add_vec("mret", 32'h3020_0073, p, 0, 0, 0, ecall_pc, 0);
    mstatus_v = mret_rule(mstatus_v);
    p = rand_pc();
    add_vec("csrrs_mstatus_mret", enc_csr(3'b010, 13, csr_mstatus, 0), p, 1, 13, mstatus_v,
            p + 4, 0);
    // load opcode is not supported here.
    p = rand_pc();
    add_vec("illegal_opcode", {12'h7FF, 5'd2, 3'b000, 5'd1, 7'b0000011}, p, 0, 1, 0, p + 4, 1);
    p = rand_pc();
    add_vec("x1_after_illegal", enc_addi(4, 1, 12'h000), p, 1, 4, x1v, p + 4, 0);
    p = rand_pc();
    add_vec("x2_after_illegal", enc_add(5, 2, 0), p, 1, 5, x2v, p + 4, 0);
  endtask

  // one instruction every cycle without gaps.
  task automatic apply_table();
    pend_t pe;
    for (int i = 0; i < vecs.size(); i++) begin
      @(negedge clk);
      inst_valid = 1'b1;
      inst = vecs[i].inst;
      pc = vecs[i].pc;
      pe.idx = i;
      pe.issue_cyc = cycle_cnt;
      pend_q.push_back(pe);
    end
    @(negedge clk);
    inst_valid = 1'b0;
    inst = '0;
    pc = '0;
  endtask

  task automatic collect_commits();
    pend_t pe;
    vec_t  v;
    string nm;
    int    waited;
    for (int n = 0; n < vecs.size(); n++) begin
      waited = 0;
      @(negedge clk);
      while (!commit_valid) begin
        waited++;
        if (waited >= 20) begin
          abort_run($sformatf("Timeout: no commit seen for entry %0d", n));
        end
        @(negedge clk);
      end
      if (pend_q.size() == 0) begin
        abort_run("A commit appeared with no instruction pending");
      end
      pe = pend_q.pop_front();
      v = vecs[pe.idx];
      nm = names[pe.idx];
      check({nm, " latency"}, pe.issue_cyc + 2, cycle_cnt);
      check({nm, " pc"}, v.pc, commit.pc);
      check({nm, " rd_wen"}, {31'b0, v.rd_wen}, {31'b0, commit.rd_wen});
      if (v.rd_wen) begin
        check({nm, " rd"}, {28'b0, v.rd}, {28'b0, commit.rd});
        check({nm, " rd_data"}, v.rd_data, commit.rd_data);
      end
      check({nm, " next_pc"}, v.next_pc, commit.next_pc);
      check({nm, " illegal"}, {31'b0, v.illegal}, {31'b0, commit.illegal});
    end
    // the strobe lasts one cycle per instruction.
    @(negedge clk);
    check("commit_valid_drop", 32'd0, {31'b0, commit_valid});
  endtask

  initial begin
    rst_n = 1'b0;
    inst_valid = 1'b0;
    inst = '0;
    pc = '0;
    void'($urandom(32'h2515_da83));
    build_table();
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    fork
      apply_table();
      collect_commits();
    join
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// File: vlog.f
source/rv_core_pkg.sv
source/inst_decode.sv
source/gpr_csr_file.sv
source/exec_commit.sv
source/rv_operand_top.sv
sim/clk_gen.sv
sim/tb_rv_operand_top.sv
